// ==== pr_pkg.sv ====
package pr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  localparam int data_w      = 128;
  localparam int strb_w      = data_w / 8;
  localparam int line_addr_w = 8;
  localparam int mem_lines   = 1 << line_addr_w;

  // Done code carried in the first result word
  localparam logic [31:0] done_code = 32'h600d_0001;

  // Core status addresses, one per rotor step
  localparam logic [2:0] stat_desc_done = 3'd0;
  localparam logic [2:0] stat_lines_wr  = 3'd1;
  localparam logic [2:0] stat_rd_resp   = 3'd2;
  localparam logic [2:0] stat_last_tag  = 3'd3;

  // Descriptor engine FSM encodings
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_read   = 3'd1;
  localparam logic [2:0] st_fold   = 3'd2;
  localparam logic [2:0] st_first  = 3'd3;
  localparam logic [2:0] st_second = 3'd4;

  //////////////////////////////////////////////////////////////////////
  // Channel payloads

  typedef struct packed {
    logic [data_w-1:0]      data;
    logic [strb_w-1:0]      strb;
    logic [line_addr_w-1:0] addr;
    logic                   last;
  } dma_wr_t;

  typedef struct packed {
    logic [line_addr_w-1:0] addr;
    logic                   last;
  } dma_rd_t;

  typedef struct packed {
    logic [15:0]            tag;
    logic [line_addr_w-1:0] start;
    logic [7:0]             count;
    logic [31:0]            rsvd;
  } in_desc_t;

  typedef struct packed {
    logic [15:0]            tag;
    logic [line_addr_w-1:0] start;
    logic [7:0]             count;
    logic [31:0]            done;
  } out_first_t;

  typedef struct packed {
    logic [63:0] checksum;
  } out_second_t;

  // Same 64-bit word, decoded by the second-word flag
  typedef union packed {
    out_first_t  first;
    out_second_t second;
  } desc_word_u;

  typedef struct packed {
    logic       is_second;
    desc_word_u word;
  } out_desc_t;

  typedef struct packed {
    logic [2:0]  addr;
    logic [31:0] data;
  } status_t;

endpackage

// ==== pipe_reg.sv ====
module pipe_reg #(
  parameter int width = 64
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [width-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [width-1:0] skid_data;
  logic             skid_valid;
  logic             s_ready_r;
  logic             s_fire;

  assign s_ready = s_ready_r;
  assign s_fire  = s_valid && s_ready_r;

  // Ready drops only while the skid register holds a word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready_r  <= 1'b0;
    end else if (skid_valid) begin
      if (m_ready) begin
        m_valid    <= 1'b1;
        skid_valid <= 1'b0;
        s_ready_r  <= 1'b1;
      end
    end else begin
      s_ready_r <= 1'b1;
      if (!m_valid || m_ready) begin
        m_valid <= s_fire;
      end else if (s_fire) begin
        skid_valid <= 1'b1;
        s_ready_r  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (skid_valid) begin
      if (m_ready) begin
        m_data <= skid_data;
      end
    end else if (!m_valid || m_ready) begin
      m_data <= s_data;
    end else if (s_fire) begin
      skid_data <= s_data;
    end
  end

  a_m_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("pipe_reg: output word changed under back-pressure");

endmodule

// ==== line_mem.sv ====
module line_mem (
  input  logic                           clk,
  input  logic                           rst_n,
  input  pr_pkg::dma_wr_t                wr,
  input  logic                           wr_valid,
  input  pr_pkg::dma_rd_t                rd,
  input  logic                           rd_valid,
  output logic                           rd_ready,
  output logic [pr_pkg::data_w-1:0]      resp_data,
  output logic                           resp_valid,
  input  logic                           resp_ready,
  input  logic [pr_pkg::line_addr_w-1:0] core_addr,
  output logic [pr_pkg::data_w-1:0]      core_data,
  output logic                           lines_wr_pulse
);

  import pr_pkg::*;

  logic [data_w-1:0] mem [mem_lines];
  logic              rd_fire;

  // A new read fits when the response slot is free or draining
  assign rd_ready       = !resp_valid || resp_ready;
  assign rd_fire        = rd_valid && rd_ready;
  assign lines_wr_pulse = wr_valid;

  //////////////////////////////////////////////////////////////////////
  // DMA write port, byte strobed

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wr.strb[b]) begin
          mem[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DMA read port with response register

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      resp_data <= mem[rd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  // Core read port, one cycle of latency
  always_ff @(posedge clk) begin
    core_data <= mem[core_addr];
  end

  // Host traffic must not read a line in the cycle it is written
  a_no_rw_clash: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid && rd_fire |-> wr.addr != rd.addr)
    else $error("line_mem: DMA read and write hit line %0d together", rd.addr);

endmodule

// ==== desc_engine.sv ====
module desc_engine (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           core_reset,
  input  logic                           enable,
  input  pr_pkg::in_desc_t               in_desc,
  input  logic                           in_valid,
  output logic                           in_taken,
  output logic [pr_pkg::line_addr_w-1:0] mem_addr,
  input  logic [pr_pkg::data_w-1:0]      mem_data,
  output pr_pkg::out_desc_t              out_desc,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic                           done_pulse,
  output logic [15:0]                    done_tag
);

  import pr_pkg::*;

  logic [2:0]             state;
  in_desc_t               desc_r;
  logic [line_addr_w-1:0] rd_ptr;
  logic [7:0]             left;
  logic                   data_vld;
  logic [63:0]            csum;

  assign in_taken   = (state == st_idle) && enable;
  assign mem_addr   = rd_ptr;
  assign out_valid  = (state == st_first) || (state == st_second);
  assign done_pulse = (state == st_second) && out_ready;
  assign done_tag   = desc_r.tag;

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (!rst_n || core_reset) begin
      state    <= st_idle;
      data_vld <= 1'b0;
    end else begin
      // Line data comes back one cycle after its address
      data_vld <= (state == st_read);
      case (state)
        st_idle: begin
          if (in_valid && in_taken) begin
            state <= (in_desc.count == 8'd0) ? st_first : st_read;
          end
        end
        st_read: begin
          if (left == 8'd1) begin
            state <= st_fold;
          end
        end
        st_fold:   state <= st_first;
        st_first: begin
          if (out_ready) begin
            state <= st_second;
          end
        end
        st_second: begin
          if (out_ready) begin
            state <= st_idle;
          end
        end
        default:   state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address walk and XOR fold

  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      desc_r <= in_desc;
      rd_ptr <= in_desc.start;
      left   <= in_desc.count;
      csum   <= '0;
    end else if (state == st_read) begin
      rd_ptr <= rd_ptr + 1'b1;
      left   <= left - 1'b1;
    end
    if (data_vld) begin
      csum <= csum ^ mem_data[127:64] ^ mem_data[63:0];
    end
  end

  always_comb begin
    out_desc           = '0;
    out_desc.is_second = (state == st_second);
    if (state == st_second) begin
      out_desc.word.second.checksum = csum;
    end else begin
      out_desc.word.first.tag   = desc_r.tag;
      out_desc.word.first.start = desc_r.start;
      out_desc.word.first.count = desc_r.count;
      out_desc.word.first.done  = done_code;
    end
  end

  a_range: assert property (@(posedge clk) disable iff (!rst_n || core_reset)
    in_valid && in_taken |-> int'(in_desc.start) + int'(in_desc.count) <= mem_lines)
    else $error("desc_engine: descriptor runs past the last line");

endmodule

// ==== status_regs.sv ====
module status_regs (
  input  logic            clk,
  input  logic            rst_n,
  input  pr_pkg::status_t wrapper_status,
  output pr_pkg::status_t core_status,
  output logic            enable,
  input  logic            done_pulse,
  input  logic [15:0]     done_tag,
  input  logic            lines_wr_pulse,
  input  logic            rd_resp_pulse
);

  import pr_pkg::*;

  logic [31:0] regs [8];
  logic [31:0] desc_done_cnt;
  logic [31:0] lines_wr_cnt;
  logic [31:0] rd_resp_cnt;
  logic [15:0] last_tag;
  logic [1:0]  rotor;

  assign enable = regs[0][0];

  // Wrapper side writes one register per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= (i == 0) ? 32'd1 : 32'd0;
      end
    end else begin
      regs[wrapper_status.addr] <= wrapper_status.data;
    end
  end

  // Event counters and rotor
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      desc_done_cnt <= '0;
      lines_wr_cnt  <= '0;
      rd_resp_cnt   <= '0;
      last_tag      <= '0;
      rotor         <= '0;
    end else begin
      rotor <= rotor + 1'b1;
      if (done_pulse) begin
        desc_done_cnt <= desc_done_cnt + 1'b1;
        last_tag      <= done_tag;
      end
      if (lines_wr_pulse) begin
        lines_wr_cnt <= lines_wr_cnt + 1'b1;
      end
      if (rd_resp_pulse) begin
        rd_resp_cnt <= rd_resp_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    core_status.addr = {1'b0, rotor};
    case (core_status.addr)
      stat_desc_done: core_status.data = desc_done_cnt;
      stat_lines_wr:  core_status.data = lines_wr_cnt;
      stat_rd_resp:   core_status.data = rd_resp_cnt;
      stat_last_tag:  core_status.data = {16'd0, last_tag};
      default:        core_status.data = '0;
    endcase
  end

endmodule

// ==== pr_core.sv ====
module pr_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      core_reset,
  input  pr_pkg::dma_wr_t           dma_wr,
  input  logic                      dma_wr_valid,
  output logic                      dma_wr_ready,
  input  pr_pkg::dma_rd_t           dma_rd,
  input  logic                      dma_rd_valid,
  output logic                      dma_rd_ready,
  output logic [pr_pkg::data_w-1:0] dma_rd_resp_data,
  output logic                      dma_rd_resp_valid,
  input  logic                      dma_rd_resp_ready,
  input  pr_pkg::in_desc_t          in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output pr_pkg::out_desc_t         out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,
  input  pr_pkg::status_t           wrapper_status,
  output pr_pkg::status_t           core_status
);

  import pr_pkg::*;

  logic [line_addr_w-1:0] mem_addr;
  logic [data_w-1:0]      mem_data;
  logic                   enable;
  logic                   done_pulse;
  logic [15:0]            done_tag;
  logic                   lines_wr_pulse;
  logic                   rd_resp_pulse;

  // Memory never back-pressures writes
  assign dma_wr_ready  = 1'b1;
  assign rd_resp_pulse = dma_rd_resp_valid && dma_rd_resp_ready;

  line_mem u_line_mem (
    .clk(clk), .rst_n(rst_n),
    .wr(dma_wr), .wr_valid(dma_wr_valid),
    .rd(dma_rd), .rd_valid(dma_rd_valid), .rd_ready(dma_rd_ready),
    .resp_data(dma_rd_resp_data), .resp_valid(dma_rd_resp_valid),
    .resp_ready(dma_rd_resp_ready),
    .core_addr(mem_addr), .core_data(mem_data),
    .lines_wr_pulse(lines_wr_pulse)
  );

  desc_engine u_desc_engine (
    .clk(clk), .rst_n(rst_n), .core_reset(core_reset), .enable(enable),
    .in_desc(in_desc), .in_valid(in_desc_valid), .in_taken(in_desc_taken),
    .mem_addr(mem_addr), .mem_data(mem_data),
    .out_desc(out_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready),
    .done_pulse(done_pulse), .done_tag(done_tag)
  );

  status_regs u_status_regs (
    .clk(clk), .rst_n(rst_n),
    .wrapper_status(wrapper_status), .core_status(core_status), .enable(enable),
    .done_pulse(done_pulse), .done_tag(done_tag),
    .lines_wr_pulse(lines_wr_pulse), .rd_resp_pulse(rd_resp_pulse)
  );

endmodule

// ==== pr_wrapper.sv ====
module pr_wrapper (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      core_reset,
  input  pr_pkg::dma_wr_t           dma_wr,
  input  logic                      dma_wr_valid,
  output logic                      dma_wr_ready,
  input  pr_pkg::dma_rd_t           dma_rd,
  input  logic                      dma_rd_valid,
  output logic                      dma_rd_ready,
  output logic [pr_pkg::data_w-1:0] dma_rd_resp_data,
  output logic                      dma_rd_resp_valid,
  input  logic                      dma_rd_resp_ready,
  input  pr_pkg::in_desc_t          in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output pr_pkg::out_desc_t         out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,
  input  pr_pkg::status_t           wrapper_status,
  output pr_pkg::status_t           core_status
);

  import pr_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Boundary resets and status

  logic rst_n_r;
  logic core_reset_r;
  logic desc_rst_n;

  always_ff @(posedge clk) begin
    rst_n_r      <= rst_n;
    core_reset_r <= core_reset;
  end

  // Descriptor stages also clear on a core reset
  assign desc_rst_n = rst_n_r && !core_reset_r;

  status_t wrapper_status_r;
  status_t core_status_n;

  always_ff @(posedge clk) begin
    wrapper_status_r <= wrapper_status;
    core_status      <= core_status_n;
  end

  //////////////////////////////////////////////////////////////////////
  // Channel registers

  dma_wr_t           dma_wr_r;
  logic              dma_wr_valid_r;
  logic              dma_wr_ready_r;
  dma_rd_t           dma_rd_r;
  logic              dma_rd_valid_r;
  logic              dma_rd_ready_r;
  logic [data_w-1:0] resp_data_n;
  logic              resp_valid_n;
  logic              resp_ready_n;
  in_desc_t          in_desc_r;
  logic              in_desc_valid_r;
  logic              in_desc_taken_r;
  out_desc_t         out_desc_n;
  logic              out_desc_valid_n;
  logic              out_desc_ready_n;
  out_desc_t         out_desc_m;
  logic              out_desc_valid_m;
  logic              out_desc_ready_m;

  pipe_reg #(.width($bits(dma_wr_t))) u_dma_wr_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(dma_wr), .s_valid(dma_wr_valid), .s_ready(dma_wr_ready),
    .m_data(dma_wr_r), .m_valid(dma_wr_valid_r), .m_ready(dma_wr_ready_r)
  );

  pipe_reg #(.width($bits(dma_rd_t))) u_dma_rd_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(dma_rd), .s_valid(dma_rd_valid), .s_ready(dma_rd_ready),
    .m_data(dma_rd_r), .m_valid(dma_rd_valid_r), .m_ready(dma_rd_ready_r)
  );

  pipe_reg #(.width(data_w)) u_rd_resp_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid),
    .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.width($bits(in_desc_t))) u_in_desc_reg (
    .clk(clk), .rst_n(desc_rst_n),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_taken_r)
  );

  // Two stages on the result path, core side then boundary side
  pipe_reg #(.width($bits(out_desc_t))) u_out_desc_core_reg (
    .clk(clk), .rst_n(desc_rst_n),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc_m), .m_valid(out_desc_valid_m), .m_ready(out_desc_ready_m)
  );

  pipe_reg #(.width($bits(out_desc_t))) u_out_desc_reg (
    .clk(clk), .rst_n(desc_rst_n),
    .s_data(out_desc_m), .s_valid(out_desc_valid_m), .s_ready(out_desc_ready_m),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Core

  pr_core u_pr_core (
    .clk(clk), .rst_n(rst_n_r), .core_reset(core_reset_r),
    .dma_wr(dma_wr_r), .dma_wr_valid(dma_wr_valid_r), .dma_wr_ready(dma_wr_ready_r),
    .dma_rd(dma_rd_r), .dma_rd_valid(dma_rd_valid_r), .dma_rd_ready(dma_rd_ready_r),
    .dma_rd_resp_data(resp_data_n), .dma_rd_resp_valid(resp_valid_n),
    .dma_rd_resp_ready(resp_ready_n),
    .in_desc(in_desc_r), .in_desc_valid(in_desc_valid_r),
    .in_desc_taken(in_desc_taken_r),
    .out_desc(out_desc_n), .out_desc_valid(out_desc_valid_n),
    .out_desc_ready(out_desc_ready_n),
    .wrapper_status(wrapper_status_r), .core_status(core_status_n)
  );

endmodule

// ==== tb_pr_wrapper.sv ====
module tb_pr_wrapper;

  import pr_pkg::*;

  localparam int wait_limit = 200;
  // Cycle budget per test summed for the watchdog
  localparam int budget_cycles = 10 + 1000 + 300 + 300 + 250 + 50;

  logic              clk;
  logic              rst_n;
  logic              core_reset;
  dma_wr_t           dma_wr;
  logic              dma_wr_valid;
  logic              dma_wr_ready;
  dma_rd_t           dma_rd;
  logic              dma_rd_valid;
  logic              dma_rd_ready;
  logic [data_w-1:0] dma_rd_resp_data;
  logic              dma_rd_resp_valid;
  logic              dma_rd_resp_ready;
  in_desc_t          in_desc;
  logic              in_desc_valid;
  logic              in_desc_taken;
  out_desc_t         out_desc;
  logic              out_desc_valid;
  logic              out_desc_ready;
  status_t           wrapper_status;
  status_t           core_status;

  // Memory model and event counts
  logic [data_w-1:0] model [mem_lines];
  int                seed = 32'h1ef5;
  int                err_cnt;
  int                tests_run;
  int                tests_passed;
  int                desc_done_cnt;
  int                lines_wr_cnt;
  int                rd_resp_cnt;
  logic [15:0]       last_tag;

  pr_wrapper dut_i (.*);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_line(input string name, input logic [data_w-1:0] got,
                            input logic [data_w-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_out_desc(input string name, input out_desc_t got, input out_desc_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Helpers entered and left on a falling edge

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [data_w-1:0] rand_line();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
  endfunction

  // Checksum from the model as upper half XOR lower half per line
  function automatic logic [63:0] xor_fold(input logic [7:0] start, input logic [7:0] count);
    logic [63:0] acc;
    logic [7:0]  idx;
    acc = '0;
    for (int i = 0; i < int'(count); i++) begin
      idx = start + 8'(i);
      acc = acc ^ model[idx][127:64] ^ model[idx][63:0];
    end
    return acc;
  endfunction

  function automatic out_desc_t first_word(input in_desc_t d);
    out_desc_t w;
    w = '0;
    w.word.first.tag   = d.tag;
    w.word.first.start = d.start;
    w.word.first.count = d.count;
    w.word.first.done  = done_code;
    return w;
  endfunction

  function automatic out_desc_t second_word(input logic [63:0] csum);
    out_desc_t w;
    w = '0;
    w.is_second = 1'b1;
    w.word.second.checksum = csum;
    return w;
  endfunction

  function automatic in_desc_t make_desc();
    in_desc_t    d;
    logic [31:0] rnd;
    rnd = rand_word();
    d.tag   = rnd[15:0];
    d.start = 8'(rnd[31:16] % 16'd24);
    d.count = 8'(rand_word() % 32'd8) + 8'd1;
    d.rsvd  = '0;
    return d;
  endfunction

  task automatic push_wr(input logic [7:0] a, input logic [data_w-1:0] d,
                         input logic [strb_w-1:0] s);
    int n;
    n = 0;
    dma_wr.data  = d;
    dma_wr.strb  = s;
    dma_wr.addr  = a;
    dma_wr.last  = 1'b1;
    dma_wr_valid = 1'b1;
    while (!dma_wr_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) begin
      $display("DMA write channel never became ready");
      err_cnt++;
    end
    @(negedge clk);
    dma_wr_valid = 1'b0;
    for (int b = 0; b < strb_w; b++) begin
      if (s[b]) model[a][b*8 +: 8] = d[b*8 +: 8];
    end
    lines_wr_cnt++;
  endtask

  task automatic push_rd(input logic [7:0] a);
    int n;
    n = 0;
    dma_rd.addr  = a;
    dma_rd.last  = 1'b1;
    dma_rd_valid = 1'b1;
    while (!dma_rd_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) begin
      $display("DMA read channel never became ready");
      err_cnt++;
    end
    @(negedge clk);
    dma_rd_valid = 1'b0;
    rd_resp_cnt++;
  endtask

  task automatic push_desc(input in_desc_t d);
    int n;
    n = 0;
    in_desc       = d;
    in_desc_valid = 1'b1;
    while (!in_desc_taken && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) begin
      $display("Descriptor input was never taken");
      err_cnt++;
    end
    @(negedge clk);
    in_desc_valid = 1'b0;
  endtask

  task automatic get_resp(output logic [data_w-1:0] d);
    int n;
    n = 0;
    while (!(dma_rd_resp_valid && dma_rd_resp_ready) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) begin
      $display("No read response arrived");
      err_cnt++;
    end
    d = dma_rd_resp_data;
    @(negedge clk);
  endtask

  // Ready optionally toggles at random while the word is pending
  task automatic get_out(output out_desc_t o, output logic ok, input bit rand_ready);
    int          n;
    logic [31:0] rnd;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < wait_limit) begin
      rnd = rand_word();
      out_desc_ready = rand_ready ? rnd[0] : 1'b1;
      if (out_desc_valid && out_desc_ready) begin
        ok = 1'b1;
      end else begin
        @(negedge clk);
        n++;
      end
    end
    o = out_desc;
    if (!ok) begin
      $display("No result word arrived on out_desc");
      err_cnt++;
    end else begin
      @(negedge clk);
    end
    out_desc_ready = 1'b0;
  endtask

  task automatic collect_result(input in_desc_t d, input bit rand_ready);
    out_desc_t got;
    logic      ok;
    get_out(got, ok, rand_ready);
    if (ok) check_out_desc("out_desc first", got, first_word(d));
    get_out(got, ok, rand_ready);
    if (ok) check_out_desc("out_desc second", got, second_word(xor_fold(d.start, d.count)));
    desc_done_cnt++;
    last_tag = d.tag;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("[%0t] %s passed", $time, name);
    end else begin
      $display("[%0t] %s failed with %0d errors", $time, name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_strobed_rw();
    int                errs;
    logic [31:0]       rnd;
    logic [data_w-1:0] d;
    errs = err_cnt;
    for (int i = 0; i < 32; i++) push_wr(8'(i), rand_line(), '1);
    // Partial writes keep old bytes where strobes are clear
    for (int i = 0; i < 16; i++) begin
      rnd = rand_word();
      push_wr({3'd0, rnd[4:0]}, rand_line(), rnd[31:16]);
    end
    repeat (4) @(negedge clk);
    for (int i = 0; i < 32; i++) begin
      push_rd(8'(i));
      get_resp(d);
      check_line("dma_rd_resp_data", d, model[8'(i)]);
    end
    report_test("strobed_rw", errs);
  endtask

  task automatic test_rd_backpressure();
    int                errs;
    logic [7:0]        addrs [8];
    logic [31:0]       rnd;
    logic [data_w-1:0] d;
    errs = err_cnt;
    for (int i = 0; i < 8; i++) begin
      rnd = rand_word();
      addrs[i] = {3'd0, rnd[4:0]};
    end
    dma_rd_resp_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) push_rd(addrs[i]);
      end
      begin
        repeat (24) @(negedge clk);
        dma_rd_resp_ready = 1'b1;
        for (int i = 0; i < 8; i++) begin
          get_resp(d);
          check_line("dma_rd_resp_data", d, model[addrs[i]]);
        end
      end
    join
    report_test("rd_backpressure", errs);
  endtask

  task automatic test_descriptor();
    int       errs;
    in_desc_t d;
    errs = err_cnt;
    d = make_desc();
    push_desc(d);
    collect_result(d, 1'b1);
    // Zero count folds to a zero checksum
    d = make_desc();
    d.count = 8'd0;
    push_desc(d);
    collect_result(d, 1'b1);
    report_test("descriptor", errs);
  endtask

  task automatic test_enable();
    int       errs;
    in_desc_t d;
    errs = err_cnt;
    wrapper_status.data = 32'd0;
    repeat (4) @(negedge clk);
    d = make_desc();
    push_desc(d);
    for (int i = 0; i < 100; i++) begin
      if (out_desc_valid) begin
        $display("Descriptor produced a result while the engine was disabled");
        err_cnt++;
        break;
      end
      @(negedge clk);
    end
    wrapper_status.data = 32'd1;
    collect_result(d, 1'b0);
    report_test("enable", errs);
  endtask

  task automatic test_core_status();
    int          errs;
    logic [1:0]  idx;
    status_t     got;
    status_t     exp;
    errs = err_cnt;
    repeat (6) @(negedge clk);
    // Rotor phase taken from the first sample
    idx = core_status.addr[1:0];
    for (int i = 0; i < 4; i++) begin
      got      = core_status;
      exp.addr = {1'b0, idx};
      case (exp.addr)
        stat_desc_done: exp.data = 32'(desc_done_cnt);
        stat_lines_wr:  exp.data = 32'(lines_wr_cnt);
        stat_rd_resp:   exp.data = 32'(rd_resp_cnt);
        default:        exp.data = {16'd0, last_tag};
      endcase
      check_status("core_status", got, exp);
      idx = idx + 2'd1;
      @(negedge clk);
    end
    report_test("core_status", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    core_reset          = 1'b0;
    dma_wr              = '0;
    dma_wr_valid        = 1'b0;
    dma_rd              = '0;
    dma_rd_valid        = 1'b0;
    dma_rd_resp_ready   = 1'b1;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    out_desc_ready      = 1'b0;
    wrapper_status.addr = 3'd0;
    wrapper_status.data = 32'd1;
    err_cnt       = 0;
    tests_run     = 0;
    tests_passed  = 0;
    desc_done_cnt = 0;
    lines_wr_cnt  = 0;
    rd_resp_cnt   = 0;
    last_tag      = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    test_strobed_rw();
    test_rd_backpressure();
    test_descriptor();
    test_enable();
    test_core_status();
    $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (budget_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", budget_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
pr_pkg.sv
pipe_reg.sv
line_mem.sv
desc_engine.sv
status_regs.sv
pr_core.sv
pr_wrapper.sv
tb_pr_wrapper.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pr_wrapper
LINT_TOP  ?= pr_wrapper
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
